//--- storeSubsystem.f
logic/memAccessPkg.sv
logic/storeBufferPkg.sv
logic/storeBuffer.sv
logic/drainController.sv
logic/occupancyCounter.sv
logic/dataMemory.sv
logic/storeSubsystem.sv
tests/clockGen.sv
tests/storeSubsystemTb.sv

//--- Makefile
TOP = storeSubsystemTb

.PHONY: all build lint clean

all: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "All tests passed!" > /dev/null

build:
	verilator --binary --timing --timescale 1ns/1ps -f storeSubsystem.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f storeSubsystem.f \
		--top-module storeSubsystem

clean:
	rm -rf obj_dir

//--- tests/storeSubsystemTb.sv
`timescale 1ns/1ps

module storeSubsystemTb;
    import memAccessPkg::*;

    localparam int depth = 4;
    localparam int occWidth = $clog2(depth + 1);
    localparam int waitLimit = 50;

    typedef enum logic [1:0] {ckNone, ckLoad, ckFlush} checkKind;

    typedef struct packed {
        logic [3:0] testId;
        memReq req;
        logic flush;
        memResp expResp;
        logic [occWidth-1:0] expOcc;
        checkKind kind;
    } stepRow;

    logic clk;
    logic rstN;
    logic reqValid;
    logic flush;
    logic stall;
    logic respValid;
    logic flushDone;
    memReq req;
    memResp resp;
    logic [occWidth-1:0] occupancy;
    stepRow steps[$];
    logic [dataWidth-1:0] refMem [256];
    logic [wordAddrWidth-1:0] refBuffer[$];     // Buffered words, oldest first
    logic [31:0] lcgState = 32'd48;
    int errorCount = 0;
    int checkCount = 0;
    int stallCount = 0;
    int maxOcc = 0;
    bit timedOut = 1'b0;

    clockGen #(.halfPeriod(10), .resetCycles(8)) clocks (.clk(clk), .rstN(rstN));

    storeSubsystem #(.depth(depth), .memWords(256)) uut (
        .clk(clk), .rstN(rstN), .reqValid(reqValid), .req(req), .flush(flush),
        .stall(stall), .respValid(respValid), .resp(resp), .flushDone(flushDone),
        .occupancy(occupancy)
    );

    // Stalls and peak occupancy for the overflow test
    always @(negedge clk) begin
        if (stall === 1'b1) begin
            stallCount <= stallCount + 1;
        end
        if (int'(occupancy) > maxOcc) begin
            maxOcc <= int'(occupancy);
        end
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic void addStep(int id, checkKind kind, memOp op, logic [addrWidth-1:0] addr);
        stepRow s;
        logic [7:0] idx;
        int lane;
        bit found;
        idx = addr[9:2];
        lane = int'(addr[1:0]);
        found = 1'b0;
        s = '0;
        s.testId = 4'(id);
        s.kind = kind;
        s.req.op = op;
        s.req.addr = addr;
        s.flush = kind == ckFlush;
        if (kind == ckFlush) begin
            refBuffer.delete();
        end else if (op == opStoreWord || op == opStoreByte) begin
            s.req.data = nextRandom();
            if (op == opStoreWord) begin
                refMem[idx] = s.req.data;
            end else begin
                refMem[idx][8*lane +: 8] = s.req.data[7:0];
            end
            foreach (refBuffer[i]) begin
                found |= refBuffer[i] == addr[15:2];
            end
            if (!found && refBuffer.size() == depth) begin
                void'(refBuffer.pop_front());           // Oldest goes to memory
            end
            if (!found) begin
                refBuffer.push_back(addr[15:2]);
            end
        end else if (op == opLoadByte) begin
            s.expResp.loadData = {24'h0, refMem[idx][8*lane +: 8]};
        end else begin
            s.expResp.loadData = refMem[idx];
        end
        s.expOcc = occWidth'(refBuffer.size());
        steps.push_back(s);
    endfunction

    task automatic checkResp(string name, memResp got, memResp exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got.loadData, exp.loadData);
        end
    endtask

    task automatic checkOccupancy(logic [occWidth-1:0] got, logic [occWidth-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("MISMATCH occupancy: got 0x%h, expected 0x%h", got, exp);
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic reportTimeout(string what);
        errorCount++;
        timedOut = 1'b1;
        $display("ERROR: timed out, %s", what);
    endtask

    task automatic waitAccept();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (stall !== 1'b0 && cycles < waitLimit) begin
            cycles++;
            @(negedge clk);
        end
        if (stall !== 1'b0) begin
            reportTimeout("stall stayed high and the request was never accepted");
        end else begin
            @(posedge clk);     // Accept edge
            #1;
        end
    endtask

    // Waits for a respValid or flushDone pulse that lasts one cycle
    task automatic waitPulse(bit forFlush, string what, memResp exp);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while ((forFlush ? flushDone : respValid) !== 1'b1 && cycles < waitLimit) begin
            cycles++;
            @(negedge clk);
        end
        if ((forFlush ? flushDone : respValid) !== 1'b1) begin
            reportTimeout($sformatf("%s never went high", what));
        end else begin
            if (!forFlush) begin
                checkResp("resp.loadData", resp, exp);
            end
            @(negedge clk);
            checkFlag(what, forFlush ? flushDone : respValid, 1'b0);
        end
    endtask

    task automatic applyStep(stepRow s);
        @(posedge clk);
        #1;
        req = s.req;
        flush = s.flush;
        reqValid = !s.flush;
        if (s.kind == ckFlush) begin
            @(posedge clk);
            #1;
            flush = 1'b0;
            waitPulse(1'b1, "flushDone", s.expResp);
        end else begin
            waitAccept();
            reqValid = 1'b0;
            if (s.kind == ckLoad && !timedOut) begin
                waitPulse(1'b0, "respValid", s.expResp);
            end
        end
        if (!timedOut) begin
            @(negedge clk);
            checkOccupancy(occupancy, s.expOcc);
        end
    endtask

    initial begin
        int testStart;
        reqValid = 1'b0;
        req = '0;
        flush = 1'b0;
        testStart = 0;
        addStep(2, ckNone, opStoreWord, 16'h0010);
        addStep(2, ckLoad, opLoadWord, 16'h0010);
        addStep(3, ckNone, opStoreByte, 16'h0011);
        addStep(3, ckNone, opStoreByte, 16'h0013);
        addStep(3, ckLoad, opLoadWord, 16'h0010);
        addStep(4, ckLoad, opLoadByte, 16'h0011);
        addStep(4, ckLoad, opLoadByte, 16'h0012);
        addStep(4, ckLoad, opLoadByte, 16'h0013);
        for (int i = 0; i < depth + 2; i++) begin
            addStep(5, ckNone, opStoreWord, 16'h0020 + 16'(4 * i));
        end
        addStep(5, ckLoad, opLoadWord, 16'h0010);   // Drained to memory by now
        addStep(5, ckLoad, opLoadWord, 16'h0020);
        addStep(5, ckLoad, opLoadByte, 16'h0026);
        addStep(6, ckFlush, opLoadWord, 16'h0000);
        addStep(6, ckLoad, opLoadWord, 16'h0010);
        for (int i = 0; i < depth + 2; i++) begin
            addStep(6, ckLoad, opLoadWord, 16'h0020 + 16'(4 * i));
        end

        for (int i = 0; i < waitLimit && rstN !== 1'b1; i++) begin
            @(posedge clk);
        end
        if (rstN !== 1'b1) begin
            reportTimeout("reset was never released");
        end else begin
            @(negedge clk);
            checkFlag("stall", stall, 1'b0);
            checkFlag("respValid", respValid, 1'b0);
            checkFlag("flushDone", flushDone, 1'b0);
            checkOccupancy(occupancy, '0);
            $display("Test 1 finished with %0d errors", errorCount);
            testStart = errorCount;
        end

        for (int i = 0; i < steps.size() && !timedOut; i++) begin
            applyStep(steps[i]);
            if (i == steps.size() - 1 || steps[i + 1].testId != steps[i].testId) begin
                if (steps[i].testId == 4'd5) begin
                    checkFlag("stallSeen", stallCount != 0, 1'b1);
                    checkFlag("occupancyAboveDepth", maxOcc > depth, 1'b0);
                end
                $display("Test %0d finished with %0d errors", steps[i].testId,
                         errorCount - testStart);
                testStart = errorCount;
            end
        end

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- tests/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int halfPeriod = 10,
    parameter int resetCycles = 8
) (
    output logic clk,
    output logic rstN
);
    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    // Released just after a rising edge
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
    end

endmodule

//--- logic/storeSubsystem.sv
`timescale 1ns/1ps

module storeSubsystem #(
    parameter int depth = 4,
    parameter int memWords = 256
) (
    input  logic clk,
    input  logic rstN,
    input  logic reqValid,
    input  memAccessPkg::memReq req,
    input  logic flush,
    output logic stall,
    output logic respValid,
    output memAccessPkg::memResp resp,
    output logic flushDone,
    output logic [$clog2(depth+1)-1:0] occupancy
);
    import memAccessPkg::*;
    import storeBufferPkg::*;

    logic accept;
    logic storeInc;
    logic storeHit;
    logic drainPop;
    logic full;
    logic empty;
    bufferEntry oldest;
    logic [dataWidth-1:0] overlayData;
    logic [laneCount-1:0] overlayMask;
    logic [dataWidth-1:0] readData;
    logic [dataWidth-1:0] mergedWord;
    logic [dataWidth-1:0] loadResult;
    logic loadPending;
    memOp loadOp;
    logic [laneBits-1:0] loadLane;

    assign accept = reqValid && !stall;
    assign storeInc = accept && isStore(req.op) && !storeHit;   // Merges take no slot

    storeBuffer #(.depth(depth)) buffer (
        .clk(clk), .rstN(rstN), .accept(accept), .req(req), .drainPop(drainPop),
        .storeHit(storeHit), .oldest(oldest), .overlayData(overlayData),
        .overlayMask(overlayMask), .occupancy(occupancy)
    );

    drainController controller (
        .clk(clk), .rstN(rstN), .reqValid(reqValid), .req(req), .storeHit(storeHit),
        .full(full), .empty(empty), .flush(flush), .stall(stall), .drainPop(drainPop),
        .flushDone(flushDone)
    );

    occupancyCounter #(.depth(depth)) counter (
        .clk(clk), .rstN(rstN), .inc(storeInc), .dec(drainPop),
        .occupancy(occupancy), .full(full), .empty(empty)
    );

    dataMemory #(.memWords(memWords)) memory (
        .clk(clk), .rstN(rstN), .writeEn(drainPop), .writeEntry(oldest),
        .readAddr(wordOf(req.addr)), .readData(readData)
    );

    // Buffered bytes win over the memory word
    always_comb begin
        for (int j = 0; j < laneCount; j++) begin
            mergedWord[8*j +: 8] = overlayMask[j] ? overlayData[8*j +: 8] : readData[8*j +: 8];
        end
        if (loadOp == opLoadByte) begin
            loadResult = dataWidth'(mergedWord[{loadLane, 3'b000} +: 8]);
        end else begin
            loadResult = mergedWord;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            loadPending <= 1'b0;
            respValid <= 1'b0;
        end else begin
            loadPending <= accept && !isStore(req.op);
            respValid <= loadPending;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            loadOp <= req.op;
            loadLane <= laneOf(req.addr);
        end
        if (loadPending) begin
            resp.loadData <= loadResult;
        end
    end

endmodule

//--- logic/dataMemory.sv
`timescale 1ns/1ps

module dataMemory #(
    parameter int memWords = 256
) (
    input  logic clk,
    input  logic rstN,
    input  logic writeEn,
    input  storeBufferPkg::bufferEntry writeEntry,
    input  logic [memAccessPkg::wordAddrWidth-1:0] readAddr,
    output logic [memAccessPkg::dataWidth-1:0] readData
);
    import memAccessPkg::*;

    localparam int idxWidth = $clog2(memWords);

    logic [dataWidth-1:0] mem [memWords];
    logic [idxWidth-1:0] writeIdx;
    logic [idxWidth-1:0] readIdx;

    assign writeIdx = writeEntry.wordAddr[idxWidth-1:0];
    assign readIdx = readAddr[idxWidth-1:0];   // Upper address bits alias

    always_ff @(posedge clk) begin
        if (writeEn) begin
            for (int j = 0; j < laneCount; j++) begin
                if (writeEntry.byteMask[j]) begin
                    mem[writeIdx][8*j +: 8] <= writeEntry.data[8*j +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            readData <= '0;
        end else begin
            readData <= mem[readIdx];
        end
    end

endmodule

//--- logic/occupancyCounter.sv
`timescale 1ns/1ps

module occupancyCounter #(
    parameter int depth = 4
) (
    input  logic clk,
    input  logic rstN,
    input  logic inc,
    input  logic dec,
    output logic [$clog2(depth+1)-1:0] occupancy,
    output logic full,
    output logic empty
);
    localparam int countWidth = $clog2(depth + 1);

    // Flags are registered from the next count
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            occupancy <= '0;
            full <= 1'b0;
            empty <= 1'b1;
        end else if (inc && !full) begin
            occupancy <= occupancy + 1'b1;
            full <= occupancy == countWidth'(depth - 1);
            empty <= 1'b0;
        end else if (dec && !empty) begin
            occupancy <= occupancy - 1'b1;
            full <= 1'b0;
            empty <= occupancy == countWidth'(1);
        end
    end

endmodule

//--- logic/drainController.sv
`timescale 1ns/1ps

module drainController (
    input  logic clk,
    input  logic rstN,
    input  logic reqValid,
    input  memAccessPkg::memReq req,
    input  logic storeHit,
    input  logic full,
    input  logic empty,
    input  logic flush,
    output logic stall,
    output logic drainPop,
    output logic flushDone
);
    import memAccessPkg::*;
    import storeBufferPkg::*;

    drainState state;
    drainState nextState;
    logic storeMiss;

    assign storeMiss = reqValid && isStore(req.op) && !storeHit;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        stall = 1'b0;
        drainPop = 1'b0;
        flushDone = 1'b0;
        case (state)
            stIdle: begin
                stall = storeMiss && full;      // Miss with no free slot
                if (flush) begin
                    nextState = stFlush;
                end else if (stall) begin
                    nextState = stDrainOne;
                end
            end
            stDrainOne: begin
                stall = 1'b1;
                drainPop = 1'b1;
                nextState = stIdle;
            end
            stFlush: begin
                stall = 1'b1;
                if (empty) begin
                    flushDone = 1'b1;
                    nextState = stIdle;
                end else begin
                    drainPop = 1'b1;            // One entry per cycle
                end
            end
            default: nextState = stIdle;
        endcase
    end

endmodule

//--- logic/storeBuffer.sv
`timescale 1ns/1ps

module storeBuffer #(
    parameter int depth = 4
) (
    input  logic clk,
    input  logic rstN,
    input  logic accept,
    input  memAccessPkg::memReq req,
    input  logic drainPop,
    output logic storeHit,
    output storeBufferPkg::bufferEntry oldest,
    output logic [memAccessPkg::dataWidth-1:0] overlayData,
    output logic [memAccessPkg::laneCount-1:0] overlayMask,
    input  logic [$clog2(depth+1)-1:0] occupancy
);
    import memAccessPkg::*;
    import storeBufferPkg::*;

    localparam int idxWidth = $clog2(depth);

    bufferEntry entries [depth];        // Index 0 is the oldest
    bufferEntry hitEntry;
    bufferEntry writeEntry;
    logic [idxWidth-1:0] hitIdx;
    logic [laneCount-1:0] storeMask;
    logic [dataWidth-1:0] storeData;
    logic [wordAddrWidth-1:0] reqWord;
    logic storeAccept;
    logic loadAccept;

    assign reqWord = wordOf(req.addr);
    assign storeAccept = accept && isStore(req.op);
    assign loadAccept = accept && !isStore(req.op);
    assign oldest = entries[0];
    assign hitEntry = entries[hitIdx];

    // Address match against valid entries only
    always_comb begin
        storeHit = 1'b0;
        hitIdx = '0;
        for (int i = 0; i < depth; i++) begin
            if (i < int'(occupancy) && entries[i].wordAddr == reqWord) begin
                storeHit = 1'b1;
                hitIdx = idxWidth'(i);
            end
        end
    end

    always_comb begin
        if (req.op == opStoreByte) begin
            storeMask = laneCount'(1) << laneOf(req.addr);
            storeData = {laneCount{req.data[7:0]}};   // Replicate into every lane
        end else begin
            storeMask = '1;
            storeData = req.data;
        end
        writeEntry.wordAddr = reqWord;
        writeEntry.byteMask = storeHit ? (hitEntry.byteMask | storeMask) : storeMask;
        for (int j = 0; j < laneCount; j++) begin
            if (storeMask[j] || !storeHit) begin
                writeEntry.data[8*j +: 8] = storeData[8*j +: 8];
            end else begin
                writeEntry.data[8*j +: 8] = hitEntry.data[8*j +: 8];
            end
        end
    end

    // A hit merges in place, a miss takes the next free slot
    always_ff @(posedge clk) begin
        if (drainPop) begin
            for (int i = 0; i < depth - 1; i++) begin
                entries[i] <= entries[i + 1];
            end
        end else if (storeAccept) begin
            for (int i = 0; i < depth; i++) begin
                if (storeHit ? (int'(hitIdx) == i) : (int'(occupancy) == i)) begin
                    entries[i] <= writeEntry;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            overlayMask <= '0;
        end else if (loadAccept) begin
            overlayMask <= storeHit ? hitEntry.byteMask : '0;  // No overlay on a miss
        end
    end

    always_ff @(posedge clk) begin
        if (loadAccept) begin
            overlayData <= hitEntry.data;
        end
    end

endmodule

//--- logic/storeBufferPkg.sv
package storeBufferPkg;

    typedef struct packed {
        logic [memAccessPkg::wordAddrWidth-1:0] wordAddr;
        logic [memAccessPkg::dataWidth-1:0] data;
        logic [memAccessPkg::laneCount-1:0] byteMask;  // Lanes that hold buffered bytes
    } bufferEntry;

    // Drain FSM
    typedef enum logic [1:0] {
        stIdle,
        stDrainOne,
        stFlush
    } drainState;

endpackage

//--- logic/memAccessPkg.sv
package memAccessPkg;

    localparam int addrWidth = 16;
    localparam int dataWidth = 32;
    localparam int laneCount = dataWidth / 8;
    localparam int laneBits = $clog2(laneCount);
    localparam int wordAddrWidth = addrWidth - laneBits;

    typedef enum logic [1:0] {
        opLoadWord,
        opLoadByte,
        opStoreWord,
        opStoreByte
    } memOp;

    typedef struct packed {
        memOp op;
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] data;     // Byte stores use bits 7:0
    } memReq;

    typedef struct packed {
        logic [dataWidth-1:0] loadData;
    } memResp;

    function automatic logic isStore(memOp op);
        return op == opStoreWord || op == opStoreByte;
    endfunction

    // Byte lane within the word
    function automatic logic [laneBits-1:0] laneOf(logic [addrWidth-1:0] addr);
        return addr[laneBits-1:0];
    endfunction

    function automatic logic [wordAddrWidth-1:0] wordOf(logic [addrWidth-1:0] addr);
        return addr[addrWidth-1:laneBits];
    endfunction

endpackage
